// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvcore_tb
FILELIST  ?= rvcore_top.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# the recipe fails unless the simulation prints the pass message on a line of its own
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/rvcore_clkgen.sv
`default_nettype none

module rvcore_clkgen (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 2;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset drops at once and is released by a nonblocking write on the second
    // rising edge, so the flops see it low on both edges
    initial begin
        rst_n = 1'b0;
        forever begin
            wait (reset_req);
            rst_n = 1'b0;
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            wait (!reset_req);
        end
    end

endmodule

`default_nettype wire

// File: bench/rvcore_tb.sv
`default_nettype none

module rvcore_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_words    = 128;
    localparam int halt_timeout  = 500;
    localparam int reset_timeout = 10;

    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [31:0] ebreak_inst = {12'd1, 5'd0, 3'b000, 5'd0, 7'b1110011};

    // funct3 of add, sub, xor, or, and, sll, srl, sra, slt, sltu with add in the low bits
    localparam logic [29:0] arith_f3 = {3'd3, 3'd2, 3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd0, 3'd0};

    logic              clk;
    logic              rst_n;
    logic              reset_req = 1'b0;
    rvcore_pkg::word_t inst;
    rvcore_pkg::word_t pc;
    logic              halt;
    rvcore_pkg::word_t halt_code;

    logic [31:0] prog [prog_words];
    int          prog_len;
    logic [31:0] lfsr_state = 32'h7b58_26d9;
    int          mismatches = 0;
    int          timeouts = 0;

    rvcore_clkgen clkgen_i (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    rvcore_top rvcore_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .pc        (pc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    // instruction memory, refreshed on every falling edge from the current pc
    initial begin
        inst = '0;
        forever begin
            @(negedge clk);
            inst = (pc[31:9] == '0) ? prog[pc[8:2]] : '0;
        end
    end

    // taps 32, 22, 2 and 1, one step for every bit handed out
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic logic [31:0] alu_expect(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a ^ b;
            3: return a | b;
            4: return a & b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return $signed(a) >>> b[4:0];
            8: return {31'd0, $signed(a) < $signed(b)};
            default: return {31'd0, a < b};
        endcase
    endfunction

    function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            mismatches++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // unused words read as zero, which the core treats as an illegal instruction
    task automatic start_program();
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic put_inst(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // addi sign-extends its low 12 bits, so the upper part is rounded up first
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        put_inst(u_type(opc_lui, rd, upper[31:12]));
        put_inst(i_type(opc_imm, 3'b000, rd, rd, {20'd0, value[11:0]}));
    endtask

    task automatic pulse_reset();
        int cycles;
        cycles = 0;
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        while (!rst_n && cycles < reset_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic wait_for_halt(input string what);
        int cycles;
        cycles = 0;
        while (!halt && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            timeouts++;
            $display("Timeout: %s never halted within %0d cycles", what, halt_timeout);
        end
    endtask

    task automatic run_to_halt(input string what, input logic [31:0] exp_code,
                               input logic [31:0] exp_pc);
        pulse_reset();
        wait_for_halt(what);
        compare({what, " halt code"}, halt_code, exp_code);
        compare({what, " final pc"}, pc, exp_pc);
    endtask

    task automatic arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int round = 0; round < 2; round++) begin
            a = next_random(32);
            b = next_random(32);
            for (int k = 0; k < 10; k++) begin
                start_program();
                load_const(1, a);
                load_const(2, b);
                put_inst(r_type((k == 1 || k == 7) ? 7'h20 : 7'h00, arith_f3[3 * k +: 3],
                                10, 1, 2));
                put_inst(ebreak_inst);
                run_to_halt($sformatf("alu op %0d round %0d", k, round), alu_expect(k, a, b),
                            4 * (prog_len - 1));
            end
        end
    endtask

    // the word at address 64 is written whole before each narrow access
    task automatic lane_access(input logic [31:0] w, input logic [31:0] v,
                               input logic [31:0] access, input bit is_store,
                               input logic [31:0] expected, input string what);
        start_program();
        load_const(1, w);
        load_const(2, v);
        put_inst(i_type(opc_imm, 3'b000, 3, 0, 64));
        put_inst(s_type(3'b010, 3, 1, 0));
        put_inst(access);
        if (is_store) begin
            put_inst(i_type(opc_load, 3'b010, 10, 3, 0));
        end
        put_inst(ebreak_inst);
        run_to_halt(what, expected, 4 * (prog_len - 1));
    endtask

    task automatic byte_lanes();
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] lane;
        logic [31:0] merged;
        w = next_random(32);
        v = next_random(32);
        for (int o = 0; o < 4; o++) begin
            lane = w >> (8 * o);
            lane_access(w, v, i_type(opc_load, 3'b000, 10, 3, o), 1'b0,
                        {{24{lane[7]}}, lane[7:0]}, $sformatf("lb offset %0d", o));
            lane_access(w, v, i_type(opc_load, 3'b100, 10, 3, o), 1'b0,
                        {24'd0, lane[7:0]}, $sformatf("lbu offset %0d", o));
            merged = w;
            merged[8 * o +: 8] = v[7:0];
            lane_access(w, v, s_type(3'b000, 3, 2, o), 1'b1, merged,
                        $sformatf("sb offset %0d", o));
            if (o % 2 == 0) begin
                lane_access(w, v, i_type(opc_load, 3'b001, 10, 3, o), 1'b0,
                            {{16{lane[15]}}, lane[15:0]}, $sformatf("lh offset %0d", o));
                lane_access(w, v, i_type(opc_load, 3'b101, 10, 3, o), 1'b0,
                            {16'd0, lane[15:0]}, $sformatf("lhu offset %0d", o));
                merged = w;
                merged[8 * o +: 16] = v[15:0];
                lane_access(w, v, s_type(3'b001, 3, 2, o), 1'b1, merged,
                            $sformatf("sh offset %0d", o));
            end
        end
    endtask

    task automatic branch_and_jump();
        logic [31:0] sum;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          blk;
        // 5 + 4 + 3 + 2 + 1 summed by a bne loop
        start_program();
        put_inst(i_type(opc_imm, 3'b000, 1, 0, 5));
        put_inst(r_type(7'h00, 3'b000, 10, 10, 1));
        put_inst(i_type(opc_imm, 3'b000, 1, 1, -1));
        put_inst(b_type(3'b001, 1, 0, -8));
        put_inst(ebreak_inst);
        run_to_halt("countdown loop", 15, 16);

        // the subroutine adds its link address, then returns through an odd jalr target
        start_program();
        put_inst(i_type(opc_imm, 3'b000, 10, 0, 1));
        put_inst(j_type(1, 12));
        put_inst(i_type(opc_imm, 3'b000, 10, 10, 100));
        put_inst(ebreak_inst);
        put_inst(r_type(7'h00, 3'b000, 10, 10, 1));
        put_inst(i_type(opc_jalr, 3'b000, 0, 1, 1));
        run_to_halt("jal and jalr", 109, 12);

        // x1 = x3 = -3 and x2 = 5, each branch runs on three register pairs
        start_program();
        put_inst(i_type(opc_imm, 3'b000, 1, 0, -3));
        put_inst(i_type(opc_imm, 3'b000, 2, 0, 5));
        put_inst(i_type(opc_imm, 3'b000, 3, 0, -3));
        sum = '0;
        blk = 0;
        for (int t = 0; t < 6; t++) begin
            f3 = (t < 2) ? t : t + 2;
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                put_inst(b_type(f3, rs1, rs2, 12));
                put_inst(i_type(opc_imm, 3'b000, 10, 10, blk + 1));
                put_inst(j_type(0, 8));
                put_inst(i_type(opc_imm, 3'b000, 10, 10, 64 * (blk + 1)));
                sum = sum + (branch_taken(f3, (rs1 == 2) ? 32'd5 : 32'hffff_fffd,
                                          (rs2 == 2) ? 32'd5 : 32'hffff_fffd)
                             ? 64 * (blk + 1) : blk + 1);
                blk++;
            end
        end
        put_inst(ebreak_inst);
        run_to_halt("branches", sum, 4 * (prog_len - 1));
    endtask

    task automatic upper_immediates();
        logic [19:0] up_lui;
        logic [19:0] up_auipc;
        up_lui = next_random(20);
        up_auipc = next_random(20);
        // auipc sits at address 8
        start_program();
        put_inst(u_type(opc_lui, 5, up_lui));
        put_inst(i_type(opc_imm, 3'b000, 0, 0, 0));
        put_inst(u_type(opc_auipc, 10, up_auipc));
        put_inst(r_type(7'h20, 3'b000, 10, 10, 5));
        put_inst(ebreak_inst);
        run_to_halt("auipc and lui", 32'd8 + {up_auipc, 12'd0} - {up_lui, 12'd0}, 16);
    endtask

    task automatic halt_freeze();
        start_program();
        put_inst(i_type(opc_imm, 3'b000, 10, 0, 42));
        put_inst(ebreak_inst);
        put_inst(i_type(opc_imm, 3'b000, 10, 0, 1));
        run_to_halt("ebreak", 42, 4);
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            compare("pc after halt", pc, 4);
            compare("halt after halt", {31'd0, halt}, 1);
            compare("halt code after halt", halt_code, 42);
        end

        start_program();
        put_inst(i_type(opc_imm, 3'b000, 10, 0, 7));
        put_inst(32'h0000_0000);
        run_to_halt("all-zero instruction", 9, 4);
    endtask

    task automatic reset_values();
        pulse_reset();
        compare("pc after reset", pc, 0);
        compare("halt after reset", {31'd0, halt}, 0);
        compare("halt code after reset", halt_code, 0);
    endtask

    initial begin
        arith_ops();
        byte_lanes();
        branch_and_jump();
        upper_immediates();
        halt_freeze();
        reset_values();
        $display("checks done with %0d mismatches and %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rvcore_top.f
+incdir+source
source/rvcore_pkg.sv
source/rvcore_bus_if.sv
source/rvcore_idu.sv
source/rvcore_regfile.sv
source/rvcore_exu.sv
source/rvcore_dmem.sv
source/rvcore_top.sv
bench/rvcore_clkgen.sv
bench/rvcore_tb.sv

// File: source/rvcore_bus_if.sv
`default_nettype none

// decoded control and operands on their way into the execute unit
interface exu_bus_if;
    rvcore_pkg::alu_op_e    alu_op;
    rvcore_pkg::src_sel_e   src_sel;
    rvcore_pkg::pc_sel_e    pc_sel;
    rvcore_pkg::branch_op_e branch_op;
    rvcore_pkg::mem_op_e    mem_op;
    logic                   rd_we;
    logic                   halt_req;
    logic                   illegal;
    rvcore_pkg::word_t      imm;
    rvcore_pkg::word_t      rs1_d;
    rvcore_pkg::word_t      rs2_d;
    rvcore_pkg::word_t      pc;

    modport decoder (output alu_op, src_sel, pc_sel, branch_op, mem_op,
                     output rd_we, halt_req, illegal, imm);
    modport regfile (output rs1_d, rs2_d);
    modport execute (input alu_op, src_sel, pc_sel, branch_op, mem_op,
                     input rd_we, halt_req, illegal, imm, rs1_d, rs2_d,
                     output pc);
endinterface

// data memory port, the read side is combinational
interface dmem_if;
    rvcore_pkg::word_t  addr;
    rvcore_pkg::word_t  wdata;
    rvcore_pkg::wmask_t wmask;
    logic               wen;
    rvcore_pkg::word_t  rdata;

    modport execute (output addr, wdata, wmask, wen, input rdata);
    modport memory  (input addr, wdata, wmask, wen, output rdata);
endinterface

`default_nettype wire

// File: source/rvcore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// core-wide constants shared by the execute unit and the data memory

// pc loaded by reset, must stay word aligned
`define RVCORE_RESET_PC 32'h0000_0000

// depth of the data memory in 32-bit words
// the word index is taken from the address bits above bit 1
`define RVCORE_DMEM_WORDS 256

// halt code reported when the decoder sees an encoding it does not know
`define RVCORE_ILLEGAL_CODE 32'd9

// ebreak reports the value held in this register as its halt code
`define RVCORE_HALT_REG 5'd10

// encoding of ebreak, the only system instruction the core accepts
`define RVCORE_EBREAK_INST 32'h0010_0073

`endif

// File: source/rvcore_dmem.sv
`default_nettype none

`include "rvcore_defines.svh"

module rvcore_dmem (
    input  logic    clk,
    dmem_if.memory  mem
);

    localparam int IDX_W = $clog2(`RVCORE_DMEM_WORDS);

    rvcore_pkg::word_t ram [`RVCORE_DMEM_WORDS];
    logic [IDX_W-1:0]  widx;

    // bits 1:0 select the byte lane, the word index sits right above them
    assign widx = mem.addr[IDX_W+1:2];

    assign mem.rdata = ram[widx];

    always_ff @(posedge clk) begin
        if (mem.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.wmask[b]) begin
                    ram[widx][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rvcore_exu.sv
`default_nettype none

`include "rvcore_defines.svh"

module rvcore_exu (
    input  logic              clk,
    input  logic              rst_n,
    exu_bus_if.execute        bus,
    dmem_if.execute           mem,
    output logic              rd_we,
    output rvcore_pkg::word_t rd_d,
    output rvcore_pkg::word_t pc,
    output logic              halt,
    output rvcore_pkg::word_t halt_code
);

    rvcore_pkg::word_t op_a, op_b, alu_res;
    rvcore_pkg::word_t pc_plus4, base, target, next_pc;
    rvcore_pkg::word_t ld_shift, ld_data;
    logic [4:0]        lane_sh;
    logic              taken;
    logic              is_load;
    logic              is_store;
    logic              is_jump;

    always_comb begin
        case (bus.src_sel)
            rvcore_pkg::src_zero_imm: {op_a, op_b} = {32'd0, bus.imm};
            rvcore_pkg::src_pc_imm:   {op_a, op_b} = {bus.pc, bus.imm};
            rvcore_pkg::src_rs1_rs2:  {op_a, op_b} = {bus.rs1_d, bus.rs2_d};
            default:                  {op_a, op_b} = {bus.rs1_d, bus.imm};
        endcase
    end

    always_comb begin
        case (bus.alu_op)
            rvcore_pkg::alu_sub:  alu_res = op_a - op_b;
            rvcore_pkg::alu_sll:  alu_res = op_a << op_b[4:0];
            rvcore_pkg::alu_slt:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            rvcore_pkg::alu_sltu: alu_res = {31'd0, op_a < op_b};
            rvcore_pkg::alu_xor:  alu_res = op_a ^ op_b;
            rvcore_pkg::alu_srl:  alu_res = op_a >> op_b[4:0];
            rvcore_pkg::alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            rvcore_pkg::alu_or:   alu_res = op_a | op_b;
            rvcore_pkg::alu_and:  alu_res = op_a & op_b;
            rvcore_pkg::alu_pass_b: alu_res = op_b;
            default:              alu_res = op_a + op_b;
        endcase
    end

    always_comb begin
        case (bus.branch_op)
            rvcore_pkg::br_ne:  taken = bus.rs1_d != bus.rs2_d;
            rvcore_pkg::br_lt:  taken = $signed(bus.rs1_d) < $signed(bus.rs2_d);
            rvcore_pkg::br_ge:  taken = $signed(bus.rs1_d) >= $signed(bus.rs2_d);
            rvcore_pkg::br_ltu: taken = bus.rs1_d < bus.rs2_d;
            rvcore_pkg::br_geu: taken = bus.rs1_d >= bus.rs2_d;
            default:            taken = bus.rs1_d == bus.rs2_d;
        endcase
    end

    // one adder serves jal, jalr and taken branches
    assign pc_plus4 = pc + 32'd4;
    assign is_jump  = (bus.pc_sel == rvcore_pkg::pc_pc_imm) ||
                      (bus.pc_sel == rvcore_pkg::pc_rs1_imm);
    assign base     = (bus.pc_sel == rvcore_pkg::pc_rs1_imm) ? bus.rs1_d : pc;
    assign target   = base + bus.imm;

    always_comb begin
        case (bus.pc_sel)
            rvcore_pkg::pc_pc_imm:  next_pc = target;
            rvcore_pkg::pc_rs1_imm: next_pc = {target[31:1], 1'b0};
            rvcore_pkg::pc_branch:  next_pc = taken ? target : pc_plus4;
            default:                next_pc = pc_plus4;
        endcase
    end

    assign is_store = (bus.mem_op == rvcore_pkg::mem_sb) ||
                      (bus.mem_op == rvcore_pkg::mem_sh) ||
                      (bus.mem_op == rvcore_pkg::mem_sw);
    assign is_load  = (bus.mem_op != rvcore_pkg::mem_none) && !is_store;

    // byte lane offset in bits, taken from the low address bits
    assign lane_sh   = {alu_res[1:0], 3'b000};
    assign mem.addr  = alu_res;
    assign mem.wdata = bus.rs2_d << lane_sh;
    assign mem.wen   = is_store && !halt;

    always_comb begin
        case (bus.mem_op)
            rvcore_pkg::mem_sb: mem.wmask = 4'b0001 << alu_res[1:0];
            rvcore_pkg::mem_sh: mem.wmask = alu_res[1] ? 4'b1100 : 4'b0011;
            rvcore_pkg::mem_sw: mem.wmask = 4'b1111;
            default:            mem.wmask = 4'b0000;
        endcase
    end

    assign ld_shift = mem.rdata >> lane_sh;
    always_comb begin
        case (bus.mem_op)
            rvcore_pkg::mem_lb:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
            rvcore_pkg::mem_lh:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
            rvcore_pkg::mem_lbu: ld_data = {24'd0, ld_shift[7:0]};
            rvcore_pkg::mem_lhu: ld_data = {16'd0, ld_shift[15:0]};
            default:             ld_data = ld_shift;
        endcase
    end

    assign rd_d  = is_load ? ld_data : (is_jump ? pc_plus4 : alu_res);
    assign rd_we = bus.rd_we && !halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= `RVCORE_RESET_PC;
            halt      <= 1'b0;
            halt_code <= '0;
        end else if (!halt) begin
            if (bus.halt_req) begin
                // pc stays on the halting instruction
                halt      <= 1'b1;
                halt_code <= bus.illegal ? `RVCORE_ILLEGAL_CODE : bus.rs1_d;
            end else begin
                pc <= next_pc;
            end
        end
    end

    assign bus.pc = pc;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

    // a store must cover its own address lane and keep the natural alignment of its size
    a_wmask_shape: assert property (@(posedge clk) disable iff (!rst_n)
        mem.wen |-> (mem.wmask[mem.addr[1:0]] &&
                     ((bus.mem_op == rvcore_pkg::mem_sb && $countones(mem.wmask) == 1) ||
                      (bus.mem_op == rvcore_pkg::mem_sh && $countones(mem.wmask) == 2 &&
                       !mem.addr[0]) ||
                      (bus.mem_op == rvcore_pkg::mem_sw && mem.wmask == 4'b1111 &&
                       mem.addr[1:0] == 2'b00))))
        else $error("store mask does not match access size");

endmodule

`default_nettype wire

// File: source/rvcore_idu.sv
`default_nettype none

`include "rvcore_defines.svh"

module rvcore_idu (
    input  rvcore_pkg::word_t    inst,
    output rvcore_pkg::reg_idx_t rs1_idx,
    output rvcore_pkg::reg_idx_t rs2_idx,
    output rvcore_pkg::reg_idx_t rd_idx,
    exu_bus_if.decoder           bus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg;
    logic       alt;
    logic       alu_ok;

    rvcore_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs2_idx = inst[24:20];
    assign rd_idx  = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct7 bit 5 picks sub and sra, for immediates only the shift uses it
    assign is_reg = (opcode == 7'b0110011);
    assign alt    = (funct7 == 7'b0100000);
    always_comb begin
        if (is_reg) begin
            alu_ok = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            alu_ok = (funct7 == 7'b0);
        end else if (funct3 == 3'b101) begin
            alu_ok = (funct7 == 7'b0) || alt;
        end else begin
            alu_ok = 1'b1;
        end
    end

    always_comb begin
        bus.alu_op    = rvcore_pkg::alu_add;
        bus.src_sel   = rvcore_pkg::src_rs1_imm;
        bus.pc_sel    = rvcore_pkg::pc_seq;
        bus.branch_op = rvcore_pkg::br_eq;
        bus.mem_op    = rvcore_pkg::mem_none;
        bus.imm       = imm_i;
        bus.rd_we     = 1'b0;
        bus.illegal   = 1'b0;
        rs1_idx       = inst[19:15];

        case (opcode)
            7'b0110111: begin
                bus.src_sel = rvcore_pkg::src_zero_imm;
                bus.alu_op  = rvcore_pkg::alu_pass_b;
                bus.imm     = imm_u;
                bus.rd_we   = 1'b1;
            end
            7'b0010111: begin
                bus.src_sel = rvcore_pkg::src_pc_imm;
                bus.imm     = imm_u;
                bus.rd_we   = 1'b1;
            end
            7'b1101111: begin
                bus.pc_sel = rvcore_pkg::pc_pc_imm;
                bus.imm    = imm_j;
                bus.rd_we  = 1'b1;
            end
            7'b1100111: begin
                bus.pc_sel  = rvcore_pkg::pc_rs1_imm;
                bus.rd_we   = 1'b1;
                bus.illegal = (funct3 != 3'b000);
            end
            7'b1100011: begin
                bus.pc_sel    = rvcore_pkg::pc_branch;
                bus.imm       = imm_b;
                bus.branch_op = rvcore_pkg::branch_op_e'(funct3);
                bus.illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            7'b0000011: begin
                bus.rd_we = 1'b1;
                case (funct3)
                    3'b000:  bus.mem_op = rvcore_pkg::mem_lb;
                    3'b001:  bus.mem_op = rvcore_pkg::mem_lh;
                    3'b010:  bus.mem_op = rvcore_pkg::mem_lw;
                    3'b100:  bus.mem_op = rvcore_pkg::mem_lbu;
                    3'b101:  bus.mem_op = rvcore_pkg::mem_lhu;
                    default: bus.illegal = 1'b1;
                endcase
            end
            7'b0100011: begin
                bus.imm = imm_s;
                case (funct3)
                    3'b000:  bus.mem_op = rvcore_pkg::mem_sb;
                    3'b001:  bus.mem_op = rvcore_pkg::mem_sh;
                    3'b010:  bus.mem_op = rvcore_pkg::mem_sw;
                    default: bus.illegal = 1'b1;
                endcase
            end
            7'b0010011, 7'b0110011: begin
                if (is_reg) begin
                    bus.src_sel = rvcore_pkg::src_rs1_rs2;
                end
                bus.rd_we   = 1'b1;
                bus.illegal = !alu_ok;
                case (funct3)
                    3'b000:  bus.alu_op = (is_reg && alt) ? rvcore_pkg::alu_sub
                                                          : rvcore_pkg::alu_add;
                    3'b001:  bus.alu_op = rvcore_pkg::alu_sll;
                    3'b010:  bus.alu_op = rvcore_pkg::alu_slt;
                    3'b011:  bus.alu_op = rvcore_pkg::alu_sltu;
                    3'b100:  bus.alu_op = rvcore_pkg::alu_xor;
                    3'b101:  bus.alu_op = alt ? rvcore_pkg::alu_sra : rvcore_pkg::alu_srl;
                    3'b110:  bus.alu_op = rvcore_pkg::alu_or;
                    default: bus.alu_op = rvcore_pkg::alu_and;
                endcase
            end
            7'b1110011: begin
                // ebreak reads x10 so the execute unit can latch it as the halt code
                rs1_idx     = `RVCORE_HALT_REG;
                bus.illegal = (inst != `RVCORE_EBREAK_INST);
            end
            default: bus.illegal = 1'b1;
        endcase

        bus.halt_req = bus.illegal || (opcode == 7'b1110011);
        if (bus.halt_req || rd_idx == 5'd0) begin
            bus.rd_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/rvcore_pkg.sv
`default_nettype none

package rvcore_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  wmask_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // operand pair fed to the ALU, first entry is the a side
    typedef enum logic [1:0] {
        src_zero_imm = 2'b00,
        src_pc_imm   = 2'b01,
        src_rs1_rs2  = 2'b10,
        src_rs1_imm  = 2'b11
    } src_sel_e;

    typedef enum logic [1:0] {
        pc_seq     = 2'b00,
        pc_pc_imm  = 2'b01,
        pc_rs1_imm = 2'b10,
        pc_branch  = 2'b11
    } pc_sel_e;

    // values follow funct3 of the branch instructions
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_op_e;

    // nine access kinds need a fourth bit
    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lh,
        mem_lw,
        mem_lbu,
        mem_lhu,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_e;

endpackage

`default_nettype wire

// File: source/rvcore_regfile.sv
`default_nettype none

module rvcore_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rvcore_pkg::reg_idx_t rs1_idx,
    input  rvcore_pkg::reg_idx_t rs2_idx,
    input  rvcore_pkg::reg_idx_t rd_idx,
    input  logic                 rd_we,
    input  rvcore_pkg::word_t    rd_d,
    exu_bus_if.regfile           bus
);

    // entry 0 is cleared by reset and never written, so x0 reads as zero
    rvcore_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_idx != 5'd0) begin
            regs[rd_idx] <= rd_d;
        end
    end

    assign bus.rs1_d = regs[rs1_idx];
    assign bus.rs2_d = regs[rs2_idx];

    // x0 must read as zero even right after a write aimed at it
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_idx == 5'd0) |-> (bus.rs1_d == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: source/rvcore_top.sv
`default_nettype none

module rvcore_top (
    input  logic              clk,
    input  logic              rst_n,
    input  rvcore_pkg::word_t inst,
    output rvcore_pkg::word_t pc,
    output logic              halt,
    output rvcore_pkg::word_t halt_code
);

    rvcore_pkg::reg_idx_t rs1_idx;
    rvcore_pkg::reg_idx_t rs2_idx;
    rvcore_pkg::reg_idx_t rd_idx;
    logic                 rd_we;
    rvcore_pkg::word_t    rd_d;

    exu_bus_if bus_i ();
    dmem_if    mem_i ();

    rvcore_idu idu_i (
        .inst    (inst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx),
        .bus     (bus_i.decoder)
    );

    // write data and enable come back from the execute unit
    rvcore_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx),
        .rd_we   (rd_we),
        .rd_d    (rd_d),
        .bus     (bus_i.regfile)
    );

    rvcore_exu exu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus_i.execute),
        .mem       (mem_i.execute),
        .rd_we     (rd_we),
        .rd_d      (rd_d),
        .pc        (pc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    rvcore_dmem dmem_i (
        .clk (clk),
        .mem (mem_i.memory)
    );

endmodule

`default_nettype wire
